//--- Makefile
# Verilator build and run for the operand-access stage

VERILATOR ?= verilator
TOP       ?= tb_vrf_access
FILELIST  ?= vrf_access.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/operand_requester.sv
////////////////////////////////////////
// Read requester for one operand queue
// Walks a command over consecutive VRF words, one per grant,
// and bids only while the queue has credit left
////////////////////////////////////////

`timescale 1ns/100ps
`include "vrf_access_defs.svh"

module operand_requester (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Command from the lane sequencer
  input  vrf_access_pkg::rd_cmd_t cmd_i,
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  // Credit return from the operand queue
  input  logic                    credit_i,
  // Bid towards the bank arbiter
  output vrf_access_pkg::rd_req_t req_o,
  input  logic                    gnt_i
);

  localparam int CRED_W = $clog2(`VA_OPQ_DEPTH + 1);

  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

  state_e                  state_q, state_d;
  vrf_access_pkg::rd_cmd_t cur_q, cur_d;
  logic [CRED_W-1:0]       credit_q, credit_d;
  vrf_access_pkg::len_t    step;

  // Elements held in one word: 8 at EW8 down to 1 at EW64
  assign step = `VA_LEN_W'(`VA_DATA_W / 8) >> cur_q.ew;

  always_comb begin
    state_d  = state_q;
    cur_d    = cur_q;
    credit_d = credit_q;

    cmd_ready_o = (state_q == IDLE);
    req_o.valid = (state_q == REQUESTING) && (credit_q != '0);
    req_o.addr  = cur_q.addr;

    // A return and a spend in the same cycle cancel out
    if (credit_i) begin
      credit_d = credit_d + 1'b1;
    end
    if (gnt_i) begin
      credit_d = credit_d - 1'b1;
    end

    case (state_q)
      IDLE: begin
        if (cmd_valid_i) begin
          cur_d = cmd_i;
          // Zero length is taken but never requested
          if (cmd_i.len != '0) begin
            state_d = REQUESTING;
          end
        end
      end
      REQUESTING: begin
        if (gnt_i) begin
          cur_d.addr = cur_q.addr + 1'b1;
          if (cur_q.len <= step) begin
            cur_d.len = '0;
            state_d   = IDLE;
          end else begin
            cur_d.len = cur_q.len - step;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      credit_q <= CRED_W'(`VA_OPQ_DEPTH);
    end else begin
      state_q  <= state_d;
      credit_q <= credit_d;
    end
  end

  always_ff @(posedge clk_i) begin
    cur_q <= cur_d;
  end

endmodule

//--- rtl/result_writeback.sv
////////////////////////////////////////
// One-entry stream register for a result port
// Holds a result until the bank arbiter grants it
////////////////////////////////////////

`timescale 1ns/100ps
`include "vrf_access_defs.svh"

module result_writeback (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Result from the functional unit
  input  vrf_access_pkg::result_t result_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  // Stored result towards the arbiter
  output vrf_access_pkg::result_t result_o,
  output logic                    bid_o,
  input  logic                    gnt_i
);

  logic                    full_q;
  vrf_access_pkg::result_t data_q;

  // Ready passes through, so a granted entry is refilled in the same cycle
  assign ready_o  = !full_q || gnt_i;
  assign bid_o    = full_q;
  assign result_o = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      full_q <= 1'b1;
    end else if (gnt_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= result_i;
    end
  end

endmodule

//--- rtl/vrf_access.sv
////////////////////////////////////////
// Operand-access stage of one lane
// Read requesters and write-back registers feed the bank arbiter
////////////////////////////////////////

`timescale 1ns/100ps
`include "vrf_access_defs.svh"

module vrf_access (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Read commands, one per operand queue
  input  vrf_access_pkg::rd_cmd_t   [`VA_NR_RD-1:0]    cmd_i,
  input  logic                      [`VA_NR_RD-1:0]    cmd_valid_i,
  output logic                      [`VA_NR_RD-1:0]    cmd_ready_o,
  input  logic                      [`VA_NR_RD-1:0]    credit_i,
  // Results to write back
  input  vrf_access_pkg::result_t   [`VA_NR_WR-1:0]    result_i,
  input  logic                      [`VA_NR_WR-1:0]    result_valid_i,
  output logic                      [`VA_NR_WR-1:0]    result_ready_o,
  // Bank requests to the VRF
  output vrf_access_pkg::bank_req_t [`VA_NR_BANKS-1:0] vrf_o
);

  vrf_access_pkg::rd_req_t [`VA_NR_RD-1:0] rd_req;
  logic                    [`VA_NR_RD-1:0] rd_gnt;
  vrf_access_pkg::result_t [`VA_NR_WR-1:0] wr_result;
  logic                    [`VA_NR_WR-1:0] wr_bid;
  logic                    [`VA_NR_WR-1:0] wr_gnt;

  for (genvar r = 0; r < `VA_NR_RD; r++) begin : gen_rd
    operand_requester i_operand_requester (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .cmd_i      (cmd_i[r]),
      .cmd_valid_i(cmd_valid_i[r]),
      .cmd_ready_o(cmd_ready_o[r]),
      .credit_i   (credit_i[r]),
      .req_o      (rd_req[r]),
      .gnt_i      (rd_gnt[r])
    );
  end

  for (genvar w = 0; w < `VA_NR_WR; w++) begin : gen_wr
    result_writeback i_result_writeback (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .result_i(result_i[w]),
      .valid_i (result_valid_i[w]),
      .ready_o (result_ready_o[w]),
      .result_o(wr_result[w]),
      .bid_o   (wr_bid[w]),
      .gnt_i   (wr_gnt[w])
    );
  end

  vrf_bank_arbiter i_vrf_bank_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_req_i   (rd_req),
    .rd_gnt_o   (rd_gnt),
    .wr_result_i(wr_result),
    .wr_bid_i   (wr_bid),
    .wr_gnt_o   (wr_gnt),
    .vrf_o      (vrf_o)
  );

endmodule

//--- rtl/vrf_access_defs.svh
////////////////////////////////////////
// Sizing macros for the VRF operand-access stage
// Included by the package and by every RTL module
////////////////////////////////////////

`ifndef VRF_ACCESS_DEFS_SVH
`define VRF_ACCESS_DEFS_SVH

// VRF organisation
`define VA_NR_BANKS  4
`define VA_BANK_BITS 2
`define VA_ADDR_W    10
`define VA_DATA_W    64

// Requesters and write-back ports
`define VA_NR_RD     2
`define VA_NR_WR     2

// Command length field, in elements
`define VA_LEN_W     9

// Credits per operand queue out of reset
`define VA_OPQ_DEPTH 4

`endif

//--- rtl/vrf_access_pkg.sv
////////////////////////////////////////
// Shared types of the operand-access stage
// Referenced with scoped names, never imported
////////////////////////////////////////

`include "vrf_access_defs.svh"

package vrf_access_pkg;

  typedef logic [`VA_ADDR_W-1:0]                 addr_t;
  typedef logic [`VA_ADDR_W-`VA_BANK_BITS-1:0]   row_t;
  typedef logic [`VA_DATA_W-1:0]                 data_t;
  typedef logic [`VA_DATA_W/8-1:0]               strb_t;
  typedef logic [`VA_LEN_W-1:0]                  len_t;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } ew_e;

  typedef struct packed {
    addr_t addr;
    len_t  len;
    ew_e   ew;
  } rd_cmd_t;

  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t be;
  } result_t;

  ////////////////////////////////////////
  // Bank payload, decoded by the wen bit
  ////////////////////////////////////////

  typedef struct packed {
    data_t wdata;
    strb_t be;
  } wr_view_t;

  typedef struct packed {
    logic [`VA_DATA_W+`VA_DATA_W/8-3:0] pad;
    logic [1:0]                         tag;
  } rd_view_t;

  typedef union packed {
    wr_view_t wr;
    rd_view_t rd;
  } bank_payload_u;

  typedef struct packed {
    logic          valid;
    logic          wen;
    row_t          row;
    bank_payload_u payload;
  } bank_req_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } rd_req_t;

endpackage

//--- rtl/vrf_bank_arbiter.sv
////////////////////////////////////////
// Per-bank VRF arbiter
// Writes win over reads; round-robin inside each class.
// Combinational grant, VRF takes every request at once
////////////////////////////////////////

`timescale 1ns/100ps
`include "vrf_access_defs.svh"

module vrf_bank_arbiter (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  vrf_access_pkg::rd_req_t   [`VA_NR_RD-1:0]    rd_req_i,
  output logic                      [`VA_NR_RD-1:0]    rd_gnt_o,
  input  vrf_access_pkg::result_t   [`VA_NR_WR-1:0]    wr_result_i,
  input  logic                      [`VA_NR_WR-1:0]    wr_bid_i,
  output logic                      [`VA_NR_WR-1:0]    wr_gnt_o,
  output vrf_access_pkg::bank_req_t [`VA_NR_BANKS-1:0] vrf_o
);

  localparam int MAX_N    = (`VA_NR_RD > `VA_NR_WR) ? `VA_NR_RD : `VA_NR_WR;
  localparam int RD_PTR_W = (`VA_NR_RD > 1) ? $clog2(`VA_NR_RD) : 1;
  localparam int WR_PTR_W = (`VA_NR_WR > 1) ? $clog2(`VA_NR_WR) : 1;

  logic [`VA_NR_BANKS-1:0][RD_PTR_W-1:0] rd_ptr_q, rd_ptr_d;
  logic [`VA_NR_BANKS-1:0][WR_PTR_W-1:0] wr_ptr_q, wr_ptr_d;

  // First request at or after ptr in circular order, -1 if none
  function automatic int rr_pick(input logic [MAX_N-1:0] req, input int ptr, input int n);
    int idx;
    int win;
    win = -1;
    for (int i = MAX_N - 1; i >= 0; i--) begin
      idx = ptr + i;
      if (idx >= n) begin
        idx = idx - n;
      end
      if (i < n && req[idx]) begin
        win = idx;
      end
    end
    return win;
  endfunction

  always_comb begin
    logic [MAX_N-1:0] wr_hit;
    logic [MAX_N-1:0] rd_hit;
    int               wr_win;
    int               rd_win;

    rd_gnt_o = '0;
    wr_gnt_o = '0;
    rd_ptr_d = rd_ptr_q;
    wr_ptr_d = wr_ptr_q;

    for (int b = 0; b < `VA_NR_BANKS; b++) begin
      wr_hit = '0;
      rd_hit = '0;
      for (int w = 0; w < `VA_NR_WR; w++) begin
        wr_hit[w] = wr_bid_i[w] &&
                    (wr_result_i[w].addr[`VA_BANK_BITS-1:0] == `VA_BANK_BITS'(b));
      end
      for (int r = 0; r < `VA_NR_RD; r++) begin
        rd_hit[r] = rd_req_i[r].valid &&
                    (rd_req_i[r].addr[`VA_BANK_BITS-1:0] == `VA_BANK_BITS'(b));
      end

      wr_win   = rr_pick(wr_hit, int'(wr_ptr_q[b]), `VA_NR_WR);
      rd_win   = rr_pick(rd_hit, int'(rd_ptr_q[b]), `VA_NR_RD);
      vrf_o[b] = '0;

      // Any write for this bank masks every read
      if (wr_win >= 0) begin
        wr_gnt_o[wr_win]          = 1'b1;
        wr_ptr_d[b]               = WR_PTR_W'((wr_win + 1) % `VA_NR_WR);
        vrf_o[b].valid            = 1'b1;
        vrf_o[b].wen              = 1'b1;
        vrf_o[b].row              = wr_result_i[wr_win].addr[`VA_ADDR_W-1:`VA_BANK_BITS];
        vrf_o[b].payload.wr.wdata = wr_result_i[wr_win].wdata;
        vrf_o[b].payload.wr.be    = wr_result_i[wr_win].be;
      end else if (rd_win >= 0) begin
        rd_gnt_o[rd_win]        = 1'b1;
        rd_ptr_d[b]             = RD_PTR_W'((rd_win + 1) % `VA_NR_RD);
        vrf_o[b].valid          = 1'b1;
        vrf_o[b].row            = rd_req_i[rd_win].addr[`VA_ADDR_W-1:`VA_BANK_BITS];
        // Tag names the operand queue the data returns to
        vrf_o[b].payload.rd.tag = 2'(rd_win);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
    end else begin
      rd_ptr_q <= rd_ptr_d;
      wr_ptr_q <= wr_ptr_d;
    end
  end

endmodule

//--- testbench/tb_vrf_access.sv
////////////////////////////////////////
// Testbench for the operand-access stage
// Drives commands, credits and results and checks every bank request
////////////////////////////////////////

`timescale 1ns/100ps
`include "vrf_access_defs.svh"

module tb_vrf_access;

  localparam int NR_RD   = `VA_NR_RD;
  localparam int NR_WR   = `VA_NR_WR;
  localparam int TIMEOUT = 4000;

  logic                                         clk_i = 1'b0;
  logic                                         rst_ni;
  vrf_access_pkg::rd_cmd_t   [NR_RD-1:0]        cmd_i;
  logic                      [NR_RD-1:0]        cmd_valid_i;
  logic                      [NR_RD-1:0]        cmd_ready_o;
  logic                      [NR_RD-1:0]        credit_i = '0;
  vrf_access_pkg::result_t   [NR_WR-1:0]        result_i;
  logic                      [NR_WR-1:0]        result_valid_i;
  logic                      [NR_WR-1:0]        result_ready_o;
  vrf_access_pkg::bank_req_t [`VA_NR_BANKS-1:0] vrf_o;

  int                      seed = 14;
  int                      errors = 0;
  int                      rd_total = 0;
  int                      wr_total = 0;
  int                      rd_cnt [NR_RD] = '{default: 0};
  int                      ret_cnt [NR_RD] = '{default: 0};
  logic [NR_RD-1:0]        hold = '0;
  logic [NR_WR-1:0]        wb_full = '0;
  vrf_access_pkg::result_t wb_val [NR_WR];
  vrf_access_pkg::addr_t   exp_rd [NR_RD][$];

  always #20 clk_i = ~clk_i;

  vrf_access i_vrf_access (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_i         (cmd_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .credit_i      (credit_i),
    .result_i      (result_i),
    .result_valid_i(result_valid_i),
    .result_ready_o(result_ready_o),
    .vrf_o         (vrf_o)
  );

  bind vrf_access vrf_access_chk i_vrf_access_chk (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_ready_i   (cmd_ready_o),
    .result_ready_i(result_ready_o),
    .vrf_i         (vrf_o)
  );

  ////////////////////////////////////////
  // Reference model and checking
  ////////////////////////////////////////

  // Words needed for a command: ceil(len * width / 64)
  function automatic int ref_reads(input vrf_access_pkg::rd_cmd_t cmd);
    int bits;
    bits = int'(cmd.len) * (8 << int'(cmd.ew));
    return (bits + `VA_DATA_W - 1) / `VA_DATA_W;
  endfunction

  task automatic note_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic abort_run(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Test failed");
    $finish;
  endtask

  task automatic check_read(input int b);
    int                    t;
    vrf_access_pkg::addr_t got;
    vrf_access_pkg::addr_t want;
    t   = int'(vrf_o[b].payload.rd.tag);
    got = {vrf_o[b].row, `VA_BANK_BITS'(b)};
    // A result accepted on an earlier edge must win its bank
    for (int w = 0; w < NR_WR; w++) begin
      if (wb_full[w] && wb_val[w].addr[`VA_BANK_BITS-1:0] == `VA_BANK_BITS'(b)) begin
        note_error($sformatf("Read on bank %0d while writer %0d held a result for it", b, w));
      end
    end
    if (t >= NR_RD) begin
      note_error($sformatf("[ERROR] vrf_o[%0d].payload.rd.tag got %h, limit %h", b, t, NR_RD));
    end else begin
      // Every read reaches its operand queue, asked for or not
      rd_cnt[t]++;
      rd_total++;
      if (exp_rd[t].size() == 0) begin
        note_error($sformatf("Queue %0d got a read on bank %0d that no command asked for", t, b));
      end else begin
        want = exp_rd[t].pop_front();
        if (got != want) begin
          note_error($sformatf("[ERROR] vrf_o[%0d] row/bank got %h/%h, expected %h/%h",
                               b, vrf_o[b].row, b, want[`VA_ADDR_W-1:`VA_BANK_BITS],
                               want[`VA_BANK_BITS-1:0]));
        end
      end
    end
  endtask

  task automatic check_write(input int b);
    vrf_access_pkg::addr_t got;
    logic                  found;
    got   = {vrf_o[b].row, `VA_BANK_BITS'(b)};
    found = 1'b0;
    for (int w = 0; w < NR_WR; w++) begin
      if (!found && wb_full[w] && wb_val[w].addr == got &&
          wb_val[w].wdata == vrf_o[b].payload.wr.wdata &&
          wb_val[w].be == vrf_o[b].payload.wr.be) begin
        wb_full[w] = 1'b0;
        found      = 1'b1;
      end
    end
    wr_total++;
    if (!found) begin
      note_error($sformatf("[ERROR] vrf_o[%0d] row=%h wdata=%h be=%h matches no pending result",
                           b, vrf_o[b].row, vrf_o[b].payload.wr.wdata, vrf_o[b].payload.wr.be));
    end
  endtask

  // Sampled at the rising edge before the DUT registers update
  always @(posedge clk_i) begin
    if (rst_ni) begin
      for (int b = 0; b < `VA_NR_BANKS; b++) begin
        if (vrf_o[b].valid && vrf_o[b].wen) begin
          check_write(b);
        end else if (vrf_o[b].valid) begin
          check_read(b);
        end
      end
      for (int q = 0; q < NR_RD; q++) begin
        if (cmd_valid_i[q] && cmd_ready_o[q]) begin
          for (int i = 0; i < ref_reads(cmd_i[q]); i++) begin
            exp_rd[q].push_back(cmd_i[q].addr + vrf_access_pkg::addr_t'(i));
          end
        end
      end
      for (int w = 0; w < NR_WR; w++) begin
        if (result_valid_i[w] && result_ready_o[w]) begin
          wb_full[w] = 1'b1;
          wb_val[w]  = result_i[w];
        end
      end
    end
  end

  // Operand queues hand back one credit per cycle for each read seen
  always @(negedge clk_i) begin
    for (int q = 0; q < NR_RD; q++) begin
      if (!hold[q] && rd_cnt[q] > ret_cnt[q]) begin
        credit_i[q] = 1'b1;
        ret_cnt[q]++;
      end else begin
        credit_i[q] = 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic send_cmd(input int q, input vrf_access_pkg::addr_t addr, input int len,
                          input int ew);
    int n;
    n = 0;
    @(negedge clk_i);
    cmd_i[q].addr  = addr;
    cmd_i[q].len   = vrf_access_pkg::len_t'(len);
    cmd_i[q].ew    = vrf_access_pkg::ew_e'(ew);
    cmd_valid_i[q] = 1'b1;
    @(posedge clk_i);
    while (!cmd_ready_o[q]) begin
      n++;
      if (n > TIMEOUT) begin
        abort_run("a command handshake");
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
    cmd_valid_i[q] = 1'b0;
  endtask

  task automatic send_result(input int w, input vrf_access_pkg::addr_t addr,
                             input vrf_access_pkg::data_t data, input vrf_access_pkg::strb_t be);
    int n;
    n = 0;
    @(negedge clk_i);
    result_i[w].addr  = addr;
    result_i[w].wdata = data;
    result_i[w].be    = be;
    result_valid_i[w] = 1'b1;
    @(posedge clk_i);
    while (!result_ready_o[w]) begin
      n++;
      if (n > TIMEOUT) begin
        abort_run("a result handshake");
      end
      @(posedge clk_i);
    end
    @(negedge clk_i);
    result_valid_i[w] = 1'b0;
  endtask

  function automatic logic credits_home();
    for (int q = 0; q < NR_RD; q++) begin
      if (rd_cnt[q] != ret_cnt[q]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic wait_idle();
    int n;
    n = 0;
    while (!(&cmd_ready_o) || wb_full != '0 || !credits_home()) begin
      n++;
      if (n > TIMEOUT) begin
        abort_run("the DUT to drain");
      end
      @(negedge clk_i);
    end
    for (int q = 0; q < NR_RD; q++) begin
      if (exp_rd[q].size() != 0) begin
        note_error($sformatf("Queue %0d went idle with %0d reads missing", q, exp_rd[q].size()));
      end
    end
  endtask

  task automatic random_reads(input int q);
    for (int i = 0; i < 8; i++) begin
      send_cmd(q, vrf_access_pkg::addr_t'($random(seed)), ($random(seed) & 31) + 1,
               $random(seed) & 3);
    end
  endtask

  task automatic random_writes(input int w);
    for (int i = 0; i < 8; i++) begin
      send_result(w, vrf_access_pkg::addr_t'($random(seed)),
                  {8'(w), 24'(i), 32'($random(seed))}, 8'($random(seed)));
    end
  endtask

  initial begin
    int base;
    int n;
    rst_ni         = 1'b0;
    cmd_i          = '0;
    cmd_valid_i    = '0;
    result_i       = '0;
    result_valid_i = '0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (cmd_ready_o != '1 || result_ready_o != '1) begin
      note_error("Ready outputs were low right after reset");
    end
    for (int b = 0; b < `VA_NR_BANKS; b++) begin
      if (vrf_o[b].valid) begin
        note_error($sformatf("Bank %0d requested right after reset", b));
      end
    end

    // Every element width on both queues
    // Queue 1 starts near the top and wraps the address space
    for (int e = 0; e < 4; e++) begin
      send_cmd(0, vrf_access_pkg::addr_t'(e * 37), 5 + e * 6, e);
      send_cmd(1, vrf_access_pkg::addr_t'(1019 + e), 17 + e, e);
      wait_idle();
    end

    // Zero length leaves the requester idle
    base = rd_cnt[1];
    send_cmd(1, vrf_access_pkg::addr_t'(341), 0, 2);
    repeat (4) begin
      @(negedge clk_i);
      if (!cmd_ready_o[1]) begin
        note_error("Queue 1 left idle after a zero-length command");
      end
    end
    if (rd_cnt[1] != base) begin
      note_error("Zero-length command produced reads");
    end

    // Withheld credits stop queue 0 after the full depth
    hold[0] = 1'b1;
    base    = rd_cnt[0];
    n       = 0;
    send_cmd(0, vrf_access_pkg::addr_t'(512), 40, 3);
    while (rd_cnt[0] - base < `VA_OPQ_DEPTH) begin
      n++;
      if (n > TIMEOUT) begin
        abort_run("reads on queue 0");
      end
      @(negedge clk_i);
    end
    repeat (12) @(negedge clk_i);
    if (rd_cnt[0] - base != `VA_OPQ_DEPTH) begin
      note_error($sformatf("Queue 0 issued %0d reads with %0d credits", rd_cnt[0] - base,
                           `VA_OPQ_DEPTH));
    end
    hold[0] = 1'b0;
    wait_idle();

    for (int i = 0; i < 8; i++) begin
      send_result(i % 2, vrf_access_pkg::addr_t'(i * 5),
                  {32'(32'hc0de_0000 + i), 32'($random(seed))}, 8'($random(seed)));
    end
    wait_idle();

    fork
      random_reads(0);
      random_reads(1);
      random_writes(0);
      random_writes(1);
    join
    wait_idle();

    $display("Reads checked: %0d, writes checked: %0d, errors: %0d", rd_total, wr_total, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- testbench/vrf_access_chk.sv
////////////////////////////////////////
// Assertions on the operand-access top level
// Attached to vrf_access with bind
////////////////////////////////////////

`timescale 1ns/100ps
`include "vrf_access_defs.svh"

module vrf_access_chk (
  input logic                                         clk_i,
  input logic                                         rst_ni,
  input logic                      [`VA_NR_RD-1:0]    cmd_ready_i,
  input logic                      [`VA_NR_WR-1:0]    result_ready_i,
  input vrf_access_pkg::bank_req_t [`VA_NR_BANKS-1:0] vrf_i
);

  logic [`VA_NR_BANKS-1:0] bad_tag;
  logic [`VA_NR_BANKS-1:0] any_valid;

  always_comb begin
    for (int b = 0; b < `VA_NR_BANKS; b++) begin
      any_valid[b] = vrf_i[b].valid;
      bad_tag[b]   = vrf_i[b].valid && !vrf_i[b].wen &&
                     (int'(vrf_i[b].payload.rd.tag) >= `VA_NR_RD);
    end
  end

  // Read tags name an existing operand queue
  tag_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni) bad_tag == '0)
    else $error("read tag names no operand queue");

  // Reset state still shows in the first cycle after release
  idle_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |->
      (&cmd_ready_i) && (&result_ready_i) && any_valid == '0)
    else $error("ready or bank valid wrong in the first cycle after reset");

endmodule

//--- vrf_access.f
+incdir+rtl
rtl/vrf_access_pkg.sv
rtl/operand_requester.sv
rtl/result_writeback.sv
rtl/vrf_bank_arbiter.sv
rtl/vrf_access.sv
testbench/vrf_access_chk.sv
testbench/tb_vrf_access.sv
